//--- design/riscv_pkg.sv
package riscv_pkg;

  // datapath and register file sizes
  localparam int xlen      = 32;
  localparam int reg_width = 5;
  localparam int reg_count = 32;

  // major opcodes handled by the slice
  localparam logic [6:0] opc_op     = 7'b0110011;
  localparam logic [6:0] opc_op_imm = 7'b0010011;
  localparam logic [6:0] opc_lui    = 7'b0110111;

  // funct3 field values
  localparam logic [2:0] f3_add_sub = 3'b000;
  localparam logic [2:0] f3_sll     = 3'b001;
  localparam logic [2:0] f3_slt     = 3'b010;
  localparam logic [2:0] f3_sltu    = 3'b011;
  localparam logic [2:0] f3_xor     = 3'b100;
  localparam logic [2:0] f3_srl_sra = 3'b101;
  localparam logic [2:0] f3_or      = 3'b110;
  localparam logic [2:0] f3_and     = 3'b111;

  // funct7 field values
  // alt selects sub and the arithmetic shift
  localparam logic [6:0] f7_base = 7'b0000000;
  localparam logic [6:0] f7_alt  = 7'b0100000;

  // alu operation codes
  localparam int alu_op_width = 4;

  localparam logic [alu_op_width-1:0] alu_add  = 4'd0;
  localparam logic [alu_op_width-1:0] alu_sub  = 4'd1;
  localparam logic [alu_op_width-1:0] alu_sll  = 4'd2;
  localparam logic [alu_op_width-1:0] alu_slt  = 4'd3;
  localparam logic [alu_op_width-1:0] alu_sltu = 4'd4;
  localparam logic [alu_op_width-1:0] alu_xor  = 4'd5;
  localparam logic [alu_op_width-1:0] alu_srl  = 4'd6;
  localparam logic [alu_op_width-1:0] alu_sra  = 4'd7;
  localparam logic [alu_op_width-1:0] alu_or   = 4'd8;
  localparam logic [alu_op_width-1:0] alu_and  = 4'd9;
  localparam logic [alu_op_width-1:0] alu_lui  = 4'd10;

endpackage

//--- design/riscv_decode.sv
`timescale 1ns/1ps

module riscv_decode import riscv_pkg::*; (
  input  logic [31:0]             instr,
  output logic [reg_width-1:0]    rs1_addr,
  output logic [reg_width-1:0]    rs2_addr,
  output logic [reg_width-1:0]    rd_addr,
  output logic [xlen-1:0]         imm,
  output logic [alu_op_width-1:0] alu_op,
  output logic                    use_imm,
  output logic                    writes_rd,
  output logic                    illegal_dec
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  // fixed field positions
  assign opcode   = instr[6:0];
  assign rd_addr  = instr[11:7];
  assign funct3   = instr[14:12];
  assign rs1_addr = instr[19:15];
  assign rs2_addr = instr[24:20];
  assign funct7   = instr[31:25];

  always_comb begin
    alu_op      = alu_add;
    use_imm     = 1'b0;
    illegal_dec = 1'b0;
    // i-type immediate, sign extended
    imm         = {{20{instr[31]}}, instr[31:20]};

    case (opcode)
      opc_op: begin
        case ({funct7, funct3})
          {f7_base, f3_add_sub}: alu_op = alu_add;
          {f7_alt,  f3_add_sub}: alu_op = alu_sub;
          {f7_base, f3_sll}:     alu_op = alu_sll;
          {f7_base, f3_slt}:     alu_op = alu_slt;
          {f7_base, f3_sltu}:    alu_op = alu_sltu;
          {f7_base, f3_xor}:     alu_op = alu_xor;
          {f7_base, f3_srl_sra}: alu_op = alu_srl;
          {f7_alt,  f3_srl_sra}: alu_op = alu_sra;
          {f7_base, f3_or}:      alu_op = alu_or;
          {f7_base, f3_and}:     alu_op = alu_and;
          default:               illegal_dec = 1'b1;
        endcase
      end

      opc_op_imm: begin
        use_imm = 1'b1;
        case (funct3)
          f3_add_sub: alu_op = alu_add;
          f3_slt:     alu_op = alu_slt;
          f3_sltu:    alu_op = alu_sltu;
          f3_xor:     alu_op = alu_xor;
          f3_or:      alu_op = alu_or;
          f3_and:     alu_op = alu_and;
          // shift amount sits in imm[4:0], upper bits must be a valid funct7
          f3_sll: begin
            if (funct7 == f7_base) begin
              alu_op = alu_sll;
            end else begin
              illegal_dec = 1'b1;
            end
          end
          f3_srl_sra: begin
            if (funct7 == f7_base) begin
              alu_op = alu_srl;
            end else if (funct7 == f7_alt) begin
              alu_op = alu_sra;
            end else begin
              illegal_dec = 1'b1;
            end
          end
          default: illegal_dec = 1'b1;
        endcase
      end

      opc_lui: begin
        use_imm = 1'b1;
        alu_op  = alu_lui;
        // u-type immediate
        imm     = {instr[31:12], 12'b0};
      end

      default: begin
        illegal_dec = 1'b1;
      end
    endcase
  end

  // x0 destination is dropped here so nothing downstream writes or forwards it
  assign writes_rd = !illegal_dec && (rd_addr != '0);

endmodule

//--- design/riscv_regfile.sv
`timescale 1ns/1ps

module riscv_regfile import riscv_pkg::*; (
  input  logic                 clk,
  input  logic                 arst_n,

  input  logic [reg_width-1:0] rs1_addr,
  output logic [xlen-1:0]      rs1_data,

  input  logic [reg_width-1:0] rs2_addr,
  output logic [xlen-1:0]      rs2_data,

  input  logic                 rd_en,
  input  logic [reg_width-1:0] rd_addr,
  input  logic [xlen-1:0]      rd_data
);

  logic [xlen-1:0] gpr [reg_count];

  // write port, x0 is never written
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < reg_count; i++) begin
        gpr[i] <= '0;
      end
    end else if (rd_en && (rd_addr != '0)) begin
      gpr[rd_addr] <= rd_data;
    end
  end

  // asynchronous reads
  // x0 is forced to zero on the read side as well
  assign rs1_data = (rs1_addr == '0) ? '0 : gpr[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 : gpr[rs2_addr];

endmodule

//--- design/riscv_alu.sv
`timescale 1ns/1ps

module riscv_alu import riscv_pkg::*; (
  input  logic                    clk,
  input  logic                    arst_n,

  input  logic                    instr_valid,
  input  logic [reg_width-1:0]    rs1_addr,
  input  logic [reg_width-1:0]    rs2_addr,
  input  logic [reg_width-1:0]    rd_addr,
  input  logic [xlen-1:0]         rs1_data,
  input  logic [xlen-1:0]         rs2_data,
  input  logic [xlen-1:0]         imm,
  input  logic [alu_op_width-1:0] alu_op,
  input  logic                    use_imm,
  input  logic                    writes_rd,
  input  logic                    illegal_dec,

  output logic                    wb_valid,
  output logic                    illegal,
  output logic [reg_width-1:0]    wb_rd,
  output logic [xlen-1:0]         wb_data
);

  logic            fwd_rs1;
  logic            fwd_rs2;
  logic [xlen-1:0] src1;
  logic [xlen-1:0] src2;
  logic [xlen-1:0] op_a;
  logic [xlen-1:0] op_b;
  logic [4:0]      shamt;
  logic [xlen-1:0] result;

  // the register file is written one cycle after the result is held here,
  // so a dependent instruction right behind takes the value from wb_data
  assign fwd_rs1 = wb_valid && (wb_rd == rs1_addr);
  assign fwd_rs2 = wb_valid && (wb_rd == rs2_addr);

  assign src1 = fwd_rs1 ? wb_data : rs1_data;
  assign src2 = fwd_rs2 ? wb_data : rs2_data;

  // operand select
  assign op_a  = src1;
  assign op_b  = use_imm ? imm : src2;
  assign shamt = op_b[4:0];

  always_comb begin
    case (alu_op)
      alu_add:  result = op_a + op_b;
      alu_sub:  result = op_a - op_b;
      alu_sll:  result = op_a << shamt;
      alu_slt:  result = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      alu_sltu: result = {{(xlen-1){1'b0}}, op_a < op_b};
      alu_xor:  result = op_a ^ op_b;
      alu_srl:  result = op_a >> shamt;
      alu_sra:  result = $unsigned($signed(op_a) >>> shamt);
      alu_or:   result = op_a | op_b;
      alu_and:  result = op_a & op_b;
      // upper immediate passes straight through
      alu_lui:  result = imm;
      default:  result = '0;
    endcase
  end

  // writeback register, one cycle of latency
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wb_valid <= 1'b0;
      illegal  <= 1'b0;
      wb_rd    <= '0;
      wb_data  <= '0;
    end else begin
      wb_valid <= instr_valid && writes_rd;
      illegal  <= instr_valid && illegal_dec;
      wb_rd    <= rd_addr;
      wb_data  <= result;
    end
  end

endmodule

//--- design/riscv_exu.sv
`timescale 1ns/1ps

module riscv_exu import riscv_pkg::*; (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 instr_valid,
  input  logic [31:0]          instr,
  output logic                 wb_valid,
  output logic [reg_width-1:0] wb_rd,
  output logic [xlen-1:0]      wb_data,
  output logic                 illegal
);

  // decoder to register file and alu
  logic [reg_width-1:0]    rs1_addr;
  logic [reg_width-1:0]    rs2_addr;
  logic [reg_width-1:0]    rd_addr;
  logic [xlen-1:0]         imm;
  logic [alu_op_width-1:0] alu_op;
  logic                    use_imm;
  logic                    writes_rd;
  logic                    illegal_dec;

  // register file read data
  logic [xlen-1:0]         rs1_data;
  logic [xlen-1:0]         rs2_data;

  riscv_decode riscv_decode_i (
    .instr       (instr),
    .rs1_addr    (rs1_addr),
    .rs2_addr    (rs2_addr),
    .rd_addr     (rd_addr),
    .imm         (imm),
    .alu_op      (alu_op),
    .use_imm     (use_imm),
    .writes_rd   (writes_rd),
    .illegal_dec (illegal_dec)
  );

  // write port fed back from the alu writeback register
  riscv_regfile riscv_regfile_i (
    .clk      (clk),
    .arst_n   (arst_n),
    .rs1_addr (rs1_addr),
    .rs1_data (rs1_data),
    .rs2_addr (rs2_addr),
    .rs2_data (rs2_data),
    .rd_en    (wb_valid),
    .rd_addr  (wb_rd),
    .rd_data  (wb_data)
  );

  riscv_alu riscv_alu_i (
    .clk         (clk),
    .arst_n      (arst_n),
    .instr_valid (instr_valid),
    .rs1_addr    (rs1_addr),
    .rs2_addr    (rs2_addr),
    .rd_addr     (rd_addr),
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data),
    .imm         (imm),
    .alu_op      (alu_op),
    .use_imm     (use_imm),
    .writes_rd   (writes_rd),
    .illegal_dec (illegal_dec),
    .wb_valid    (wb_valid),
    .illegal     (illegal),
    .wb_rd       (wb_rd),
    .wb_data     (wb_data)
  );

endmodule

//--- verif/riscv_exu_checker.sv
`timescale 1ns/1ps

module riscv_exu_checker import riscv_pkg::*; (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 instr_valid,
  input  logic [31:0]          instr,
  input  logic                 wb_valid,
  input  logic [reg_width-1:0] wb_rd,
  input  logic [xlen-1:0]      wb_data,
  input  logic                 illegal,
  input  int                   test_id,
  output int                   checked,
  output int                   errors
);

  logic [xlen-1:0]      model [reg_count];
  logic                 pending = 1'b0;
  logic                 exp_instr;
  logic                 exp_valid;
  logic                 exp_illegal;
  logic [reg_width-1:0] exp_rd;
  logic [xlen-1:0]      exp_data;
  int                   exp_test;
  int                   check_count = 0;
  int                   error_count = 0;

  assign checked = check_count;
  assign errors  = error_count;

  function automatic string test_name(input int id);
    case (id)
      0:       return "reset_state";
      1:       return "imm_ops";
      2:       return "reg_ops";
      3:       return "forwarding";
      4:       return "x0_rule";
      5:       return "illegal";
      default: return "unknown";
    endcase
  endfunction

  // rv32i result of one instruction, returns 0 for unsupported encodings
  function automatic logic predict(input logic [31:0] w, input logic [xlen-1:0] a,
                                   input logic [xlen-1:0] b_reg,
                                   output logic [xlen-1:0] res);
    logic [6:0]      opc;
    logic [2:0]      f3;
    logic [6:0]      f7;
    logic [xlen-1:0] b;
    logic [4:0]      sh;
    logic            alt_ok;
    logic            legal;
    opc   = w[6:0];
    f3    = w[14:12];
    f7    = w[31:25];
    legal = 1'b1;
    res   = '0;
    if (opc == opc_lui) begin
      res = {w[31:12], 12'h000};
    end else if (opc == opc_op || opc == opc_op_imm) begin
      b  = (opc == opc_op) ? b_reg : {{20{w[31]}}, w[31:20]};
      sh = b[4:0];
      case (f3)
        3'b000:  res = (opc == opc_op && f7 == 7'h20) ? a - b : a + b;
        3'b001:  res = a << sh;
        3'b010:  res = {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
        3'b011:  res = {{(xlen-1){1'b0}}, a < b};
        3'b100:  res = a ^ b;
        3'b101: begin
          if (f7 == 7'h20) begin
            res = $unsigned($signed(a) >>> sh);
          end else begin
            res = a >> sh;
          end
        end
        3'b110:  res = a | b;
        default: res = a & b;
      endcase
      // funct7 only matters for register ops and immediate shifts
      if (opc == opc_op || f3 == 3'b001 || f3 == 3'b101) begin
        alt_ok = (f3 == 3'b000 && opc == opc_op) || f3 == 3'b101;
        legal  = (f7 == 7'h00) || (f7 == 7'h20 && alt_ok);
      end
    end else begin
      legal = 1'b0;
    end
    return legal;
  endfunction

  task automatic compare(input string field, input logic [31:0] expv,
                         input logic [31:0] actv);
    if (actv !== expv) begin
      $display("FAILED %s %s expected %h actual %h", test_name(exp_test), field, expv, actv);
      error_count++;
    end
  endtask

  // model update at issue, so a dependent instruction sees the new value at once
  always @(posedge clk or negedge arst_n) begin : model_update
    logic [xlen-1:0]      res;
    logic                 legal;
    logic [reg_width-1:0] rd;
    if (!arst_n) begin
      for (int i = 0; i < reg_count; i++) begin
        model[i] = '0;
      end
      pending = 1'b0;
    end else begin
      pending     = 1'b1;
      exp_instr   = instr_valid;
      exp_test    = test_id;
      exp_valid   = 1'b0;
      exp_illegal = 1'b0;
      exp_rd      = '0;
      exp_data    = '0;
      if (instr_valid) begin
        rd          = instr[11:7];
        legal       = predict(instr, model[instr[19:15]], model[instr[24:20]], res);
        exp_illegal = !legal;
        if (legal && rd != '0) begin
          exp_valid = 1'b1;
          exp_rd    = rd;
          exp_data  = res;
          model[rd] = res;
        end
      end
    end
  end

  // outputs are stable half a cycle after the edge
  always @(negedge clk) begin
    if (!arst_n) begin
      if (wb_valid !== 1'b0 || illegal !== 1'b0 || wb_rd !== '0 || wb_data !== '0) begin
        $display("outputs are not cleared while reset is asserted");
        error_count++;
      end
    end else if (pending) begin
      compare("wb_valid", {31'b0, exp_valid}, {31'b0, wb_valid});
      compare("illegal", {31'b0, exp_illegal}, {31'b0, illegal});
      if (exp_valid) begin
        compare("wb_rd", {27'b0, exp_rd}, {27'b0, wb_rd});
        compare("wb_data", exp_data, wb_data);
      end
      if (exp_instr) begin
        check_count++;
      end
    end
  end

endmodule

//--- verif/tb_riscv_exu.sv
`timescale 1ns/1ps

module tb_riscv_exu import riscv_pkg::*; ();

  logic                 clk = 1'b0;
  logic                 arst_n;
  logic                 instr_valid;
  logic [31:0]          instr;
  logic                 wb_valid;
  logic [reg_width-1:0] wb_rd;
  logic [xlen-1:0]      wb_data;
  logic                 illegal;

  int          test_id;
  int          checked;
  int          errors;
  int          sent;
  int          test_errors_start;
  int          tests_passed;
  int          tests_failed;
  logic [31:0] rng_state;

  always #50 clk = ~clk;

  riscv_exu riscv_exu_i (
    .clk         (clk),
    .arst_n      (arst_n),
    .instr_valid (instr_valid),
    .instr       (instr),
    .wb_valid    (wb_valid),
    .wb_rd       (wb_rd),
    .wb_data     (wb_data),
    .illegal     (illegal)
  );

  riscv_exu_checker riscv_exu_checker_i (
    .clk         (clk),
    .arst_n      (arst_n),
    .instr_valid (instr_valid),
    .instr       (instr),
    .wb_valid    (wb_valid),
    .wb_rd       (wb_rd),
    .wb_data     (wb_data),
    .illegal     (illegal),
    .test_id     (test_id),
    .checked     (checked),
    .errors      (errors)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  function automatic logic [4:0] rand_reg();
    logic [31:0] r;
    r = next_rand();
    return r[4:0];
  endfunction

  function automatic logic [4:0] nonzero_reg();
    logic [4:0] n;
    n = rand_reg();
    return (n == 5'd0) ? 5'd1 : n;
  endfunction

  // instruction encoders
  function automatic logic [31:0] r_type_word(input logic [6:0] f7, input logic [2:0] f3,
                                              input logic [4:0] rd, input logic [4:0] rs1,
                                              input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, opc_op};
  endfunction

  function automatic logic [31:0] i_type_word(input logic [11:0] imm12, input logic [4:0] rs1,
                                              input logic [2:0] f3, input logic [4:0] rd);
    return {imm12, rs1, f3, rd, opc_op_imm};
  endfunction

  function automatic logic [31:0] u_type_word(input logic [19:0] imm20, input logic [4:0] rd);
    return {imm20, rd, opc_lui};
  endfunction

  function automatic logic [31:0] imm_op_word(input logic [4:0] rd, input logic [4:0] rs1);
    logic [31:0] r;
    r = next_rand();
    // shifts keep a legal funct7 above the shift amount
    if (r[2:0] == 3'b001) begin
      return i_type_word({7'h00, r[12:8]}, rs1, r[2:0], rd);
    end
    if (r[2:0] == 3'b101) begin
      return i_type_word({r[3] ? 7'h20 : 7'h00, r[12:8]}, rs1, r[2:0], rd);
    end
    return i_type_word(r[31:20], rs1, r[2:0], rd);
  endfunction

  function automatic logic [31:0] reg_op_word(input logic [4:0] rd, input logic [4:0] rs1,
                                              input logic [4:0] rs2);
    logic [31:0] r;
    logic        alt_ok;
    r      = next_rand();
    alt_ok = (r[2:0] == 3'b000) || (r[2:0] == 3'b101);
    return r_type_word((alt_ok && r[3]) ? 7'h20 : 7'h00, r[2:0], rd, rs1, rs2);
  endfunction

  function automatic logic [31:0] illegal_word();
    logic [31:0] r;
    r = next_rand();
    case (r[1:0])
      // load opcode, then m extension, bad slli funct7, bad and funct7
      2'd0:    return {r[31:7], 7'b0000011};
      2'd1:    return r_type_word(7'h01, r[14:12], r[11:7], r[19:15], r[24:20]);
      2'd2:    return i_type_word({7'h20, r[24:20]}, r[19:15], 3'b001, r[11:7]);
      default: return r_type_word(7'h20, 3'b111, r[11:7], r[19:15], r[24:20]);
    endcase
  endfunction

  task automatic issue(input logic [31:0] word);
    @(negedge clk);
    instr_valid = 1'b1;
    instr       = word;
    sent++;
  endtask

  task automatic idle();
    @(negedge clk);
    instr_valid = 1'b0;
    instr       = next_rand();
  endtask

  task automatic random_gap();
    logic [31:0] r;
    r = next_rand();
    if (r[1:0] == 2'd0) begin
      idle();
    end
  endtask

  task automatic start_test(input int id);
    @(negedge clk);
    test_id = id;
    @(posedge clk);
    test_errors_start = errors;
  endtask

  task automatic finish_test(input string name);
    int waited;
    idle();
    waited = 0;
    do begin
      @(posedge clk);
      waited++;
    end while (checked != sent && waited < 20);
    if (checked != sent) begin
      tests_failed++;
      $display("timeout in %s waiting for the checker, %0d of %0d instructions compared",
               name, checked, sent);
    end else if (errors == test_errors_start) begin
      tests_passed++;
      $display("test %s passed", name);
    end else begin
      tests_failed++;
      $display("test %s failed with %0d mismatches", name, errors - test_errors_start);
    end
  endtask

  initial begin : stimulus
    logic [31:0] r;
    logic [31:0] word;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  last_rd;
    rng_state    = 32'd97431;
    arst_n       = 1'b0;
    instr_valid  = 1'b0;
    instr        = '0;
    test_id      = 0;
    sent         = 0;
    tests_passed = 0;
    tests_failed = 0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;

    // every add gives zero while all registers are still zero
    start_test(0);
    for (int i = 0; i < 4; i++) begin
      idle();
    end
    for (int i = 0; i < 8; i++) begin
      issue(r_type_word(7'h00, 3'b000, rand_reg(), rand_reg(), rand_reg()));
    end
    finish_test("reset_state");

    start_test(1);
    for (int i = 0; i < 60; i++) begin
      r = next_rand();
      if (r[2:0] == 3'd0) begin
        issue(u_type_word(r[31:12], nonzero_reg()));
      end else begin
        issue(imm_op_word(nonzero_reg(), rand_reg()));
      end
      random_gap();
    end
    finish_test("imm_ops");

    start_test(2);
    for (int i = 0; i < 80; i++) begin
      issue(reg_op_word(nonzero_reg(), rand_reg(), rand_reg()));
      random_gap();
    end
    finish_test("reg_ops");

    // back to back chains mostly reading the previous destination
    start_test(3);
    last_rd = 5'd1;
    for (int i = 0; i < 100; i++) begin
      r   = next_rand();
      rs1 = (r[1:0] != 2'd0) ? last_rd : rand_reg();
      rs2 = r[2] ? last_rd : rand_reg();
      rd  = nonzero_reg();
      if (r[3]) begin
        issue(reg_op_word(rd, rs1, rs2));
      end else begin
        issue(imm_op_word(rd, rs1));
      end
      last_rd = rd;
    end
    finish_test("forwarding");

    start_test(4);
    for (int i = 0; i < 40; i++) begin
      r   = next_rand();
      rd  = r[0] ? 5'd0 : nonzero_reg();
      rs1 = r[1] ? 5'd0 : rand_reg();
      rs2 = r[2] ? 5'd0 : rand_reg();
      word = r[3] ? reg_op_word(rd, rs1, rs2) : imm_op_word(rd, rs1);
      issue(word);
      random_gap();
    end
    finish_test("x0_rule");

    // a legal reader follows each illegal word on its rd field
    start_test(5);
    last_rd = 5'd1;
    for (int i = 0; i < 60; i++) begin
      r = next_rand();
      if (r[1:0] == 2'd0) begin
        word = illegal_word();
      end else if (r[2]) begin
        word = reg_op_word(nonzero_reg(), last_rd, rand_reg());
      end else begin
        word = imm_op_word(nonzero_reg(), last_rd);
      end
      last_rd = word[11:7];
      issue(word);
      if (r[5:3] == 3'd0) begin
        idle();
      end
    end
    finish_test("illegal");

    $display("tests passed %0d, failed %0d, mismatches %0d", tests_passed, tests_failed, errors);
    if (tests_failed == 0 && errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

//--- tb.f
design/riscv_pkg.sv
design/riscv_decode.sv
design/riscv_regfile.sv
design/riscv_alu.sv
design/riscv_exu.sv
verif/riscv_exu_checker.sv
verif/tb_riscv_exu.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -f tb.f \
  --top-module tb_riscv_exu -o sim_tb_riscv_exu

./obj_dir/sim_tb_riscv_exu > sim.log 2>&1 || true
cat sim.log

if grep -q "TB FAILED" sim.log; then
  echo "simulation reported a failure"
  exit 1
fi
